// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_vlsu -o sim_vlsu
out=$(./obj_dir/sim_vlsu)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"

// ==== tb_vlsu.sv ====
/*
 * Testbench for the vector load/store unit
 * Runs a command table against a Wishbone memory model and checks
 * memory and the destination register against a byte level model
 */
`timescale 1ns/1ns

module tb_vlsu import vlsu_pkg::*; ();

    localparam int TIMEOUT = 400;       // Cycles allowed per command

    localparam vreg_t NO_IDX = '0;
    localparam vreg_t DAT_A  = 128'hc3a1_5e27_9b04_d86f_12e9_7c35_a0f4_6b8d;
    localparam vreg_t DAT_B  = 128'h8e31_f6a9_0b7d_42c5_d3e8_1f60_a52b_79c4;
    localparam vreg_t DAT_C  = 128'h6d2f_b804_e193_57ca_3c8b_f017_92a6_4de5;
    localparam vreg_t IDX_B  = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
    localparam vreg_t IDX_H  = 128'h0000_0040_0002_0062_0010_0080_00a4_0036;
    localparam vreg_t IDX_W  = 128'h0000000c_00000000_00000020_00000004;

    typedef struct packed {
        logic      store;
        mode_t     mode;
        sew_t      sew;
        elem_idx_t vl;
        addr_t     base;
        addr_t     stride;
        vreg_t     vs2;             // Byte offsets in indexed mode
        vreg_t     vs3;             // Store data
        logic      exp_err;
        logic      poke;            // Second start while busy
    } row_t;

    logic      clk, n_rst, start, is_store;
    mode_t     mode;
    sew_t      sew;
    elem_idx_t vl;
    addr_t     base, stride, wb_adr;
    vreg_t     vs2, vs3, vd, exp_vd;
    logic      busy, done, error;
    logic      wb_cyc, wb_stb, wb_we, wb_ack;
    word_t     wb_dat_o, wb_dat_i;
    sel_t      wb_sel;

    row_t       tbl[$];
    logic [7:0] ref_mem [256];      // Expected memory contents
    int         cyc_cnt = 0;        // Cycles with wb_cyc high
    int         chk_cnt = 0;
    int         err_cnt = 0;
    int         tmo_cnt = 0;

    vlsu_top i_vlsu_top (.*);

    tb_wb_mem i_mem (
        .clk, .n_rst, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_i(wb_dat_o), .sel(wb_sel), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        if (wb_cyc) cyc_cnt <= cyc_cnt + 1;

    task automatic check_vreg(input vreg_t got, input vreg_t exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input addr_t adr);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: memory word %h got %h expected %h",
                     $time, adr, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input logic st, input mode_t md, input sew_t sw, input elem_idx_t n,
                           input addr_t b, input addr_t s, input vreg_t v2, input vreg_t v3,
                           input logic ee, input logic pk);
        tbl.push_back({st, md, sw, n, b, s, v2, v3, ee, pk});
    endtask

    // Byte address of element i
    function automatic logic [7:0] elem_addr(input row_t r, input int i);
        int    eb;
        int    k;
        addr_t off;
        eb  = 1 << r.sew;
        off = '0;
        for (k = 0; k < eb; k++)
            off[8*k +: 8] = r.vs2[8*(i*eb + k) +: 8];   // Index element, zero extended
        case (r.mode)
            MODE_UNIT:   return 8'(r.base + addr_t'(i * eb));
            MODE_STRIDE: return 8'(r.base + addr_t'(i) * r.stride);
            default:     return 8'(r.base + off);
        endcase
    endfunction

    // Applies one legal command to the expected memory and vd
    task automatic model_row(input row_t r);
        int         i;
        int         k;
        int         eb;
        logic [7:0] a;
        eb     = 1 << r.sew;
        exp_vd = '0;                                // Tail of a load is zero
        for (i = 0; i < int'(r.vl); i++) begin
            a = elem_addr(r, i);
            for (k = 0; k < eb; k++) begin
                if (r.store)
                    ref_mem[a + 8'(k)] = r.vs3[8*(i*eb + k) +: 8];
                else
                    exp_vd[8*(i*eb + k) +: 8] = ref_mem[a + 8'(k)];
            end
        end
    endtask

    task automatic compare_mem();
        int    w;
        word_t got;
        word_t exp;
        for (w = 0; w < 64; w++) begin
            got = {i_mem.mem[4*w+3], i_mem.mem[4*w+2], i_mem.mem[4*w+1], i_mem.mem[4*w]};
            exp = {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]};
            check_word(got, exp, addr_t'(4 * w));
        end
    endtask

    task automatic run_row(input row_t r, input int n);
        int t;
        int cyc0;
        @(negedge clk);
        start    = 1'b1;
        is_store = r.store;
        mode     = r.mode;
        sew      = r.sew;
        vl       = r.vl;
        base     = r.base;
        stride   = r.stride;
        vs2      = r.vs2;
        vs3      = r.vs3;
        cyc0     = cyc_cnt;
        @(negedge clk);
        start    = 1'b0;
        is_store = ~r.store;                        // Unit runs on its latched copy
        mode     = ~r.mode;
        sew      = ~r.sew;
        vl       = ~r.vl;
        base     = ~r.base;
        stride   = ~r.stride;
        vs2      = ~r.vs2;
        vs3      = ~r.vs3;
        t = 0;
        while (!done && t < TIMEOUT) begin
            start = r.poke && (t == 3);             // Must be dropped while busy
            if (start)
                check_flag(busy, 1'b1, "busy at second start");
            @(negedge clk);
            t++;
        end
        start = 1'b0;
        if (!done) begin
            tmo_cnt++;
            $display("Row %0d timed out, no done within %0d cycles", n, TIMEOUT);
        end else begin
            check_flag(error, r.exp_err, "error flag");
            check_flag(busy, r.exp_err, "busy at done");    // Falls with done unless rejected
            if (!r.exp_err) begin
                compare_mem();
                if (!r.store)
                    check_vreg(vd, exp_vd, "vd");
            end
            @(negedge clk);
            check_flag(done, 1'b0, "done one cycle later");
            check_flag(busy, 1'b0, "busy one cycle after done");
            if (r.exp_err)
                check_flag(logic'(cyc_cnt != cyc0) | wb_cyc, 1'b0,
                           "wb_cyc on rejected command");
        end
    endtask

    initial begin
        int i;
        n_rst    = 1'b0;
        start    = 1'b0;
        is_store = 1'b0;
        mode     = MODE_UNIT;
        sew      = SEW_E8;
        vl       = '0;
        base     = '0;
        stride   = '0;
        vs2      = '0;
        vs3      = '0;

        // store  mode  sew  vl  base  stride  vs2  vs3  error  poke
        add_row(1'b1, MODE_UNIT, SEW_E8, 5'd16, 32'h00, 32'h0, NO_IDX, DAT_A, 1'b0, 1'b0);
        add_row(1'b0, MODE_UNIT, SEW_E8, 5'd16, 32'h00, 32'h0, NO_IDX, DAT_C, 1'b0, 1'b0);
        add_row(1'b1, MODE_UNIT, SEW_E16, 5'd8, 32'h20, 32'h0, NO_IDX, DAT_B, 1'b0, 1'b0);
        add_row(1'b0, MODE_UNIT, SEW_E16, 5'd5, 32'h20, 32'h0, NO_IDX, DAT_A, 1'b0, 1'b0);
        add_row(1'b1, MODE_UNIT, SEW_E32, 5'd4, 32'h40, 32'h0, NO_IDX, DAT_C, 1'b0, 1'b1);
        add_row(1'b0, MODE_UNIT, SEW_E32, 5'd3, 32'h40, 32'h0, NO_IDX, DAT_B, 1'b0, 1'b0);
        add_row(1'b1, MODE_STRIDE, SEW_E16, 5'd4, 32'h60, 32'h6, NO_IDX, DAT_A, 1'b0, 1'b0);
        add_row(1'b1, MODE_STRIDE, SEW_E8, 5'd6, 32'h81, 32'h5, NO_IDX, DAT_B, 1'b0, 1'b0);
        add_row(1'b0, MODE_STRIDE, SEW_E32, 5'd4, 32'h60, 32'h8, NO_IDX, DAT_C, 1'b0, 1'b0);
        add_row(1'b0, MODE_INDEX, SEW_E8, 5'd16, 32'h00, 32'h0, IDX_B, DAT_A, 1'b0, 1'b0);
        add_row(1'b0, MODE_INDEX, SEW_E16, 5'd8, 32'h20, 32'h0, IDX_H, DAT_A, 1'b0, 1'b0);
        add_row(1'b1, MODE_INDEX, SEW_E32, 5'd4, 32'h90, 32'h0, IDX_W, DAT_C, 1'b0, 1'b0);
        add_row(1'b0, MODE_INDEX, SEW_E32, 5'd4, 32'h90, 32'h0, IDX_W, DAT_B, 1'b0, 1'b1);
        add_row(1'b1, MODE_UNIT, SEW_BAD, 5'd4, 32'h00, 32'h0, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b0, MODE_UNIT, SEW_E8, 5'd0, 32'h00, 32'h0, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b0, MODE_UNIT, SEW_E32, 5'd5, 32'h00, 32'h0, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b1, MODE_UNIT, SEW_E16, 5'd4, 32'h21, 32'h0, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b0, MODE_BAD, SEW_E8, 5'd4, 32'h00, 32'h0, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b1, MODE_STRIDE, SEW_E32, 5'd4, 32'h40, 32'h6, NO_IDX, DAT_A, 1'b1, 1'b0);
        add_row(1'b0, MODE_UNIT, SEW_E8, 5'd16, 32'h80, 32'h0, NO_IDX, DAT_B, 1'b0, 1'b0);

        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        for (i = 0; i < 256; i++)
            ref_mem[i] = i_mem.mem[i];          // Start from the model's fill pattern

        foreach (tbl[n]) begin
            if (!tbl[n].exp_err)
                model_row(tbl[n]);
            run_row(tbl[n], n);
        end

        $display("Checks %0d, mismatches %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb_wb_mem.sv ====
/*
 * Wishbone classic memory model
 * 256 bytes with byte selects, 0 to 3 random wait cycles per ack
 */
`timescale 1ns/1ns

module tb_wb_mem import vlsu_pkg::*; (
    input  logic  clk,
    input  logic  n_rst,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  addr_t adr,
    input  word_t dat_i,
    input  sel_t  sel,
    output word_t dat_o,
    output logic  ack
);

    logic [7:0]  mem [256];
    logic [31:0] lfsr;
    logic [1:0]  wait_cnt;      // Wait cycles still to go
    logic        pend;          // Request seen, wait count drawn

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always_ff @(posedge clk or negedge n_rst) begin : bus
        logic [31:0] s1;
        logic [31:0] s2;
        logic [1:0]  w;
        word_t       rd;
        int          i;
        if (!n_rst) begin
            for (i = 0; i < 256; i++)
                mem[i] <= 8'(i * 37 + 90);      // Distinct byte per address
            lfsr     <= 32'h3283_3920;
            wait_cnt <= 2'd0;
            pend     <= 1'b0;
            ack      <= 1'b0;
            dat_o    <= '0;
        end else begin
            ack <= 1'b0;                        // Ack lasts one cycle
            if (cyc && stb && !ack) begin
                if (pend) begin
                    w = wait_cnt;
                end else begin
                    s1   = lfsr_step(lfsr);     // One step per bit taken
                    s2   = lfsr_step(s1);
                    lfsr <= s2;
                    w    = {s1[0], s2[0]};
                end
                if (w == 2'd0) begin
                    ack  <= 1'b1;
                    pend <= 1'b0;
                    for (i = 0; i < SEL_W; i++) begin
                        rd[8*i +: 8] = mem[{adr[7:2], 2'(i)}];
                        if (we && sel[i])
                            mem[{adr[7:2], 2'(i)}] <= dat_i[8*i +: 8];
                    end
                    dat_o <= rd;
                end else begin
                    pend     <= 1'b1;
                    wait_cnt <= w - 2'd1;
                end
            end
        end
    end

endmodule

// ==== verilog.f ====
vlsu_pkg.sv
vlsu_cfg.sv
vlsu_agu.sv
vlsu_data.sv
vlsu_ctrl.sv
vlsu_top.sv
tb_wb_mem.sv
tb_vlsu.sv

// ==== vlsu_agu.sv ====
/*
 * Load/store address generation
 * Element counter and per-element byte address for unit, strided and
 * indexed access
 */
`timescale 1ns/1ns

module vlsu_agu import vlsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      first,        // Start of a command, element 0
    input  logic      step,         // Advance to next element
    input  mode_t     cfg_mode,
    input  sew_t      cfg_sew,
    input  elem_idx_t cfg_vl,
    input  addr_t     cfg_base,
    input  addr_t     cfg_stride,
    input  vreg_t     cfg_vs2,
    output addr_t     adr,
    output elem_idx_t elem_idx,
    output logic      last
);

    elem_idx_t cnt;
    elem_idx_t nxt_idx;     // Element the next address belongs to
    addr_t     idx_off;     // Byte offset from the index register
    addr_t     idx_adr;

    assign nxt_idx = first ? elem_idx_t'(0) : cnt + 1'b1;
    assign idx_off = addr_t'(get_elem(cfg_vs2, cfg_sew, nxt_idx));
    assign idx_adr = cfg_base + idx_off;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            cnt <= '0;
            adr <= '0;
        end else if (first) begin
            cnt <= '0;
            adr <= (cfg_mode == MODE_INDEX) ? idx_adr : cfg_base;
        end else if (step) begin
            cnt <= nxt_idx;
            case (cfg_mode)
                MODE_UNIT:   adr <= adr + elem_bytes(cfg_sew);  // Packed elements
                MODE_STRIDE: adr <= adr + cfg_stride;
                MODE_INDEX:  adr <= idx_adr;                    // Gather or scatter
                default:     adr <= adr;
            endcase
        end
    end

    assign elem_idx = cnt;
    assign last     = (cnt == cfg_vl - 1'b1);

    // Counter never runs past the element count
    a_cnt_bound: assert property (@(posedge clk) disable iff (!n_rst)
        step |=> (cnt < cfg_vl));

endmodule

// ==== vlsu_cfg.sv ====
/*
 * Load/store configuration block
 * Captures one command on accept and flags illegal settings
 */
`timescale 1ns/1ns

module vlsu_cfg import vlsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      accept,       // Command taken by the controller
    input  logic      is_store,
    input  mode_t     mode,
    input  sew_t      sew,
    input  elem_idx_t vl,
    input  addr_t     base,
    input  addr_t     stride,
    input  vreg_t     vs2,
    input  vreg_t     vs3,
    output logic      cfg_store,
    output mode_t     cfg_mode,
    output sew_t      cfg_sew,
    output elem_idx_t cfg_vl,
    output addr_t     cfg_base,
    output addr_t     cfg_stride,
    output vreg_t     cfg_vs2,
    output vreg_t     cfg_vs3,
    output logic      cfg_err
);

    addr_t align_mask;  // Low address bits that must be clear

    // Command fields
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            cfg_store  <= 1'b0;
            cfg_mode   <= MODE_UNIT;
            cfg_sew    <= SEW_E8;
            cfg_vl     <= '0;
            cfg_base   <= '0;
            cfg_stride <= '0;
        end else if (accept) begin
            cfg_store  <= is_store;
            cfg_mode   <= mode;
            cfg_sew    <= sew;
            cfg_vl     <= vl;
            cfg_base   <= base;
            cfg_stride <= stride;
        end
    end

    // Register operands, payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_vs2 <= vs2;     // Byte offsets for indexed mode
            cfg_vs3 <= vs3;     // Store data
        end
    end

    assign align_mask = elem_bytes(cfg_sew) - addr_t'(1);

    assign cfg_err = (cfg_sew == SEW_BAD)
                   | (cfg_mode == MODE_BAD)
                   | (cfg_vl == '0)
                   | (cfg_vl > vl_max(cfg_sew))                 // Does not fit VLEN
                   | ((cfg_base & align_mask) != '0)           // Misaligned base
                   | ((cfg_mode == MODE_STRIDE) && ((cfg_stride & align_mask) != '0));

    // A legal command never runs past the register
    a_vl_bound: assert property (@(posedge clk) disable iff (!n_rst)
        !cfg_err |-> (int'(cfg_vl) * int'(elem_bytes(cfg_sew)) <= VLEN / 8));

endmodule

// ==== vlsu_ctrl.sv ====
/*
 * Load/store controller
 * Accepts a command, checks it, and runs one Wishbone classic
 * transfer per element with an idle strobe cycle between them
 */
`timescale 1ns/1ns

module vlsu_ctrl import vlsu_pkg::*; (
    input  logic clk,
    input  logic n_rst,
    input  logic start,
    input  logic cfg_store,
    input  logic cfg_err,
    input  logic last,          // Current element is the final one
    input  logic wb_ack,
    output logic accept,        // Latch command fields
    output logic first,
    output logic step,
    output logic busy,
    output logic done,
    output logic error,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we
);

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        LOAD_XFER,
        STORE_XFER,
        GAP
    } lsu_state_e;

    lsu_state_e state, state_nxt;
    lsu_state_e xfer_st;        // Transfer state for this command
    logic       xfer;           // Strobe phase
    logic       fail;           // Command rejected
    logic       done_q;         // End of last transfer

    assign xfer_st = cfg_store ? STORE_XFER : LOAD_XFER;
    assign xfer    = (state == LOAD_XFER) || (state == STORE_XFER);
    assign fail    = (state == CHECK) && cfg_err;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (start) state_nxt = CHECK;
            CHECK:      state_nxt = cfg_err ? IDLE : xfer_st;
            LOAD_XFER,
            STORE_XFER: if (wb_ack) state_nxt = last ? IDLE : GAP;
            GAP:        state_nxt = xfer_st;    // Next address settles here
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_q <= xfer && wb_ack && last;
        end
    end

    assign accept = (state == IDLE) && start;     // Start while busy is dropped
    assign first  = (state == CHECK) && !cfg_err;
    assign step   = xfer && wb_ack && !last;
    assign busy   = (state != IDLE);
    assign done   = done_q | fail;
    assign error  = fail;

    // Bus held through wait states, cyc kept over the gap
    assign wb_stb = xfer;
    assign wb_cyc = xfer || (state == GAP);
    assign wb_we  = (state == STORE_XFER) || ((state == GAP) && cfg_store);

    // Direction held for the whole bus cycle
    a_we_steady: assert property (@(posedge clk) disable iff (!n_rst)
        $past(wb_cyc) && wb_cyc |-> $stable(wb_we));

    // One idle strobe cycle after every ack
    a_stb_gap: assert property (@(posedge clk) disable iff (!n_rst)
        wb_stb && wb_ack |=> !wb_stb);

endmodule

// ==== vlsu_data.sv ====
/*
 * Load/store data path
 * Places store elements on their byte lane with selects, and gathers
 * load lanes into the destination register image
 */
`timescale 1ns/1ns

module vlsu_data import vlsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      first,        // Start of a command
    input  logic      wb_ack,       // Load data valid on wb_dat_i
    input  logic      cfg_store,
    input  sew_t      cfg_sew,
    input  vreg_t     cfg_vs3,
    input  addr_t     adr,
    input  elem_idx_t elem_idx,
    input  word_t     wb_dat_i,
    output word_t     wb_dat_o,
    output sel_t      wb_sel,
    output vreg_t     vd
);

    logic [LANE_W-1:0] lane;        // Byte lane of the current element
    logic [LANE_W+2:0] lane_sh;     // Same lane as a bit shift
    sel_t              lane_mask;   // Selects of one element at lane 0
    word_t             st_elem;
    word_t             ld_lane;

    assign lane    = adr[LANE_W-1:0];
    assign lane_sh = {lane, 3'b000};

    // Store side
    assign st_elem   = get_elem(cfg_vs3, cfg_sew, elem_idx);
    assign lane_mask = sel_t'((32'd1 << elem_bytes(cfg_sew)) - 32'd1);
    assign wb_sel    = lane_mask << lane;
    assign wb_dat_o  = st_elem << lane_sh;

    // Load side, element moved down to bit 0
    assign ld_lane = wb_dat_i >> lane_sh;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vd <= '0;
        end else if (!cfg_store) begin
            if (first) begin
                vd <= '0;                           // Tail stays zero
            end else if (wb_ack) begin
                case (cfg_sew)
                    SEW_E8:  vd[elem_idx*8 +: 8]   <= ld_lane[7:0];
                    SEW_E16: vd[elem_idx*16 +: 16] <= ld_lane[15:0];
                    SEW_E32: vd[elem_idx*32 +: 32] <= ld_lane[31:0];
                    default: vd <= vd;              // Rejected before any transfer
                endcase
            end
        end
    end

    // Every transferred element stays inside one bus word
    a_lane_fit: assert property (@(posedge clk) disable iff (!n_rst)
        wb_ack |-> ((wb_sel >> lane) == lane_mask));

endmodule

// ==== vlsu_pkg.sv ====
/*
 * Vector load/store unit shared definitions
 * Bus and register widths, field encodings and element-size helpers
 */
package vlsu_pkg;

    localparam int XLEN      = 32;              // Scalar and address width
    localparam int VLEN      = 128;             // Bits in one vector register
    localparam int BUS_W     = 32;              // Wishbone data width
    localparam int SEL_W     = BUS_W / 8;       // Byte selects
    localparam int LANE_W    = $clog2(SEL_W);   // Address bits that pick the byte lane
    localparam int MAX_ELEMS = VLEN / 8;        // Element count at 8 bits

    typedef logic [XLEN-1:0]                addr_t;
    typedef logic [BUS_W-1:0]               word_t;
    typedef logic [SEL_W-1:0]               sel_t;
    typedef logic [VLEN-1:0]                vreg_t;
    typedef logic [$clog2(MAX_ELEMS+1)-1:0] elem_idx_t;  // 0 .. MAX_ELEMS
    typedef logic [1:0]                     sew_t;
    typedef logic [1:0]                     mode_t;

    // Element width codes
    localparam sew_t SEW_E8  = 2'd0;
    localparam sew_t SEW_E16 = 2'd1;
    localparam sew_t SEW_E32 = 2'd2;
    localparam sew_t SEW_BAD = 2'd3;

    // Addressing modes
    localparam mode_t MODE_UNIT   = 2'd0;
    localparam mode_t MODE_STRIDE = 2'd1;
    localparam mode_t MODE_INDEX  = 2'd2;
    localparam mode_t MODE_BAD    = 2'd3;

    // Bytes per element
    function automatic addr_t elem_bytes(sew_t sew);
        case (sew)
            SEW_E16: return addr_t'(2);
            SEW_E32: return addr_t'(4);
            default: return addr_t'(1);     // E8, and the illegal code
        endcase
    endfunction

    // Elements that fit one register
    function automatic elem_idx_t vl_max(sew_t sew);
        case (sew)
            SEW_E8:  return elem_idx_t'(VLEN / 8);
            SEW_E16: return elem_idx_t'(VLEN / 16);
            SEW_E32: return elem_idx_t'(VLEN / 32);
            default: return '0;
        endcase
    endfunction

    // Element n of a register, zero extended to a bus word
    function automatic word_t get_elem(vreg_t v, sew_t sew, elem_idx_t n);
        case (sew)
            SEW_E8:  return word_t'(v[n*8 +: 8]);
            SEW_E16: return word_t'(v[n*16 +: 16]);
            SEW_E32: return word_t'(v[n*32 +: 32]);
            default: return '0;
        endcase
    endfunction

endpackage

// ==== vlsu_top.sv ====
/*
 * Vector load/store unit top
 * Command capture, controller, address generation and data path
 * behind one Wishbone classic master
 */
`timescale 1ns/1ns

module vlsu_top import vlsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      start,
    input  logic      is_store,
    input  mode_t     mode,
    input  sew_t      sew,
    input  elem_idx_t vl,
    input  addr_t     base,
    input  addr_t     stride,
    input  vreg_t     vs2,          // Index register
    input  vreg_t     vs3,          // Store data register
    output logic      busy,
    output logic      done,
    output logic      error,
    output vreg_t     vd,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output addr_t     wb_adr,
    output word_t     wb_dat_o,
    output sel_t      wb_sel,
    input  word_t     wb_dat_i,
    input  logic      wb_ack
);

    logic      accept, first, step, last;
    logic      cfg_store, cfg_err;
    mode_t     cfg_mode;
    sew_t      cfg_sew;
    elem_idx_t cfg_vl, elem_idx;
    addr_t     cfg_base, cfg_stride;
    vreg_t     cfg_vs2, cfg_vs3;

    vlsu_cfg i_vlsu_cfg (
        .clk, .n_rst, .accept, .is_store, .mode, .sew, .vl, .base, .stride,
        .vs2, .vs3, .cfg_store, .cfg_mode, .cfg_sew, .cfg_vl, .cfg_base,
        .cfg_stride, .cfg_vs2, .cfg_vs3, .cfg_err
    );

    vlsu_ctrl i_vlsu_ctrl (
        .clk, .n_rst, .start, .cfg_store, .cfg_err, .last, .wb_ack,
        .accept, .first, .step, .busy, .done, .error, .wb_cyc, .wb_stb, .wb_we
    );

    vlsu_agu i_vlsu_agu (
        .clk, .n_rst, .first, .step, .cfg_mode, .cfg_sew, .cfg_vl, .cfg_base,
        .cfg_stride, .cfg_vs2, .adr(wb_adr), .elem_idx, .last
    );

    vlsu_data i_vlsu_data (
        .clk, .n_rst, .first, .wb_ack, .cfg_store, .cfg_sew, .cfg_vs3,
        .adr(wb_adr), .elem_idx, .wb_dat_i, .wb_dat_o, .wb_sel, .vd
    );

endmodule
